// ==== noc_params.sv ====
`default_nettype none

package noc_params;

    // ##################################################
    // mesh and router geometry
    // ##################################################
    localparam int MESH_SIZE_X = 3;
    localparam int MESH_SIZE_Y = 3;
    localparam int DEST_ADDR_SIZE_X = 2;  // wide enough for any column of the mesh.
    localparam int DEST_ADDR_SIZE_Y = 2;

    localparam int VC_NUM = 2;
    localparam int PORT_NUM = 5;

    localparam int PAYLOAD_SIZE = 16;
    localparam int HEAD_DATA_SIZE = PAYLOAD_SIZE - DEST_ADDR_SIZE_X - DEST_ADDR_SIZE_Y;

    typedef logic [DEST_ADDR_SIZE_X-1:0] x_addr_t;
    typedef logic [DEST_ADDR_SIZE_Y-1:0] y_addr_t;
    typedef logic [$clog2(VC_NUM)-1:0] vc_id_t;
    typedef logic [PAYLOAD_SIZE-1:0] payload_t;

    // port order matches the index of every per-port array in the router.
    typedef enum logic [2:0] {LOCAL, NORTH, SOUTH, WEST, EAST} port_t;

    typedef enum logic [1:0] {HEAD, BODY, TAIL, HEADTAIL} flit_label_t;

    // ##################################################
    // flit formats
    // ##################################################
    // A head flit carries its destination in the top bits of the payload.
    typedef struct packed {
        x_addr_t                   x_dest;
        y_addr_t                   y_dest;
        logic [HEAD_DATA_SIZE-1:0] head_data;
    } head_payload_t;

    typedef struct packed {
        flit_label_t label;
        vc_id_t      vc_id;
        payload_t    payload;
    } flit_t;

    // ##################################################
    // allocator handshakes
    // ##################################################
    typedef struct packed {
        logic  valid;
        port_t out_port;
    } va_req_t;

    typedef struct packed {
        logic   valid;
        vc_id_t vc_new;  // downstream VC that now belongs to the packet.
    } va_grant_t;

    typedef struct packed {
        logic   valid;
        port_t  out_port;
        vc_id_t vc_new;
        logic   is_tail;
    } sa_req_t;

    typedef enum logic [1:0] {IDLE, VA, ACTIVE} vc_state_t;

endpackage

`default_nettype wire

// ==== rc_unit.sv ====
`default_nettype none

module rc_unit import noc_params::*; #(
    parameter int X_CURRENT = MESH_SIZE_X / 2,
    parameter int Y_CURRENT = MESH_SIZE_Y / 2
) (
    input  wire x_addr_t x_dest_i,
    input  wire y_addr_t y_dest_i,
    output port_t        out_port_o
);

    // Dimension order routing: the X offset is resolved before any Y hop is taken.
    always_comb
    begin
        if (int'(x_dest_i) > X_CURRENT)
        begin
            out_port_o = EAST;
        end
        else if (int'(x_dest_i) < X_CURRENT)
        begin
            out_port_o = WEST;
        end
        else if (int'(y_dest_i) > Y_CURRENT)
        begin
            out_port_o = SOUTH;  // y grows towards the south edge.
        end
        else if (int'(y_dest_i) < Y_CURRENT)
        begin
            out_port_o = NORTH;
        end
        else
        begin
            out_port_o = LOCAL;  // the packet has arrived.
        end
    end

endmodule

`default_nettype wire

// ==== input_buffer.sv ====
`default_nettype none

module input_buffer import noc_params::*; #(
    parameter int BUFFER_SIZE = 8,
    parameter int PIPELINE_DEPTH = 2
) (
    input  wire logic      clk,
    input  wire logic      reset_i,
    input  wire flit_t     data_i,
    input  wire logic      write_i,
    input  wire logic      read_i,
    input  wire port_t     out_port_i,
    input  wire va_grant_t va_grant_i,
    output flit_t          data_o,
    output va_req_t        va_req_o,
    output sa_req_t        sa_req_o,
    output logic           on_off_o,
    output logic           is_empty_o
);

    localparam int PTR_W = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1;

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [$clog2(BUFFER_SIZE+1)-1:0] count_t;

    flit_t     mem [BUFFER_SIZE];
    port_t     route_mem [BUFFER_SIZE];  // route computed when each flit arrived.
    ptr_t      wr_ptr_q;
    ptr_t      rd_ptr_q;
    count_t    count_q;
    vc_state_t state_q;
    port_t     route_q;
    vc_id_t    vc_new_q;
    logic      is_full;
    logic      front_is_head;
    logic      front_is_tail;

    function automatic ptr_t next_ptr(ptr_t ptr);
        if (ptr == ptr_t'(BUFFER_SIZE - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    // ##################################################
    // circular flit storage
    // ##################################################
    always_ff @(posedge clk)
    begin
        if (write_i)
        begin
            mem[wr_ptr_q] <= data_i;
            route_mem[wr_ptr_q] <= out_port_i;  // only a head's entry is ever looked at.
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end
        else
        begin
            if (write_i)
                wr_ptr_q <= next_ptr(wr_ptr_q);
            if (read_i)
                rd_ptr_q <= next_ptr(rd_ptr_q);
            count_q <= count_q + count_t'(write_i) - count_t'(read_i);
        end
    end

    assign data_o = mem[rd_ptr_q];
    assign is_empty_o = (count_q == '0);
    assign is_full = (count_q == count_t'(BUFFER_SIZE));

    // The upstream router still has flits in flight when it sees off.
    assign on_off_o = (count_q <= count_t'(BUFFER_SIZE - PIPELINE_DEPTH));

    assign front_is_head = !is_empty_o && (data_o.label == HEAD || data_o.label == HEADTAIL);
    assign front_is_tail = (data_o.label == TAIL) || (data_o.label == HEADTAIL);

    // ##################################################
    // packet state machine
    // ##################################################
    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            state_q <= IDLE;
            route_q <= LOCAL;
            vc_new_q <= '0;
        end
        else
        begin
            unique case (state_q)
                IDLE:
                begin
                    if (front_is_head)
                    begin
                        state_q <= VA;
                        route_q <= route_mem[rd_ptr_q];
                    end
                end
                VA:
                begin
                    if (va_grant_i.valid)
                    begin
                        state_q <= ACTIVE;
                        vc_new_q <= va_grant_i.vc_new;
                    end
                end
                ACTIVE:
                begin
                    if (read_i && front_is_tail)
                        state_q <= IDLE;  // next packet starts over with its head.
                end
                default:
                begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_comb
    begin
        va_req_o.valid = (state_q == VA);
        va_req_o.out_port = route_q;
        sa_req_o.valid = (state_q == ACTIVE) && !is_empty_o;
        sa_req_o.out_port = route_q;
        sa_req_o.vc_new = vc_new_q;
        sa_req_o.is_tail = front_is_tail;
    end

    // upstream on/off and the switch allocator keep these from ever firing.
    a_no_overflow: assert property (@(posedge clk) disable iff (reset_i) write_i |-> !is_full)
        else $error("flit written into a full buffer.");
    a_no_underflow: assert property (@(posedge clk) disable iff (reset_i) read_i |-> !is_empty_o)
        else $error("flit read from an empty buffer.");

endmodule

`default_nettype wire

// ==== input_port.sv ====
`default_nettype none

module input_port import noc_params::*; #(
    parameter int BUFFER_SIZE = 8,
    parameter int PIPELINE_DEPTH = 2,
    parameter int X_CURRENT = MESH_SIZE_X / 2,
    parameter int Y_CURRENT = MESH_SIZE_Y / 2
) (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire flit_t                  data_i,
    input  wire logic                   valid_flit_i,
    input  wire va_grant_t [VC_NUM-1:0] va_grant_i,
    input  wire vc_id_t                 sa_vc_sel_i,
    input  wire logic                   sa_read_i,
    output flit_t                       flit_o,
    output va_req_t [VC_NUM-1:0]        va_req_o,
    output sa_req_t [VC_NUM-1:0]        sa_req_o,
    output logic [VC_NUM-1:0]           on_off_o
);

    flit_t [VC_NUM-1:0] vc_data;
    logic [VC_NUM-1:0]  write_cmd;
    logic [VC_NUM-1:0]  read_cmd;
    logic [VC_NUM-1:0]  is_empty;
    head_payload_t      head;
    port_t              route;

    assign head = head_payload_t'(data_i.payload);  // meaningful for head flits only.

    rc_unit #(
        .X_CURRENT(X_CURRENT),
        .Y_CURRENT(Y_CURRENT)
    ) u_rc (
        .x_dest_i(head.x_dest),
        .y_dest_i(head.y_dest),
        .out_port_o(route)
    );

    for (genvar vc = 0; vc < VC_NUM; vc++)
    begin : g_vc
        input_buffer #(
            .BUFFER_SIZE(BUFFER_SIZE),
            .PIPELINE_DEPTH(PIPELINE_DEPTH)
        ) u_buffer (
            .clk(clk),
            .reset_i(reset_i),
            .data_i(data_i),
            .write_i(write_cmd[vc]),
            .read_i(read_cmd[vc]),
            .out_port_i(route),
            .va_grant_i(va_grant_i[vc]),
            .data_o(vc_data[vc]),
            .va_req_o(va_req_o[vc]),
            .sa_req_o(sa_req_o[vc]),
            .on_off_o(on_off_o[vc]),
            .is_empty_o(is_empty[vc])
        );
    end

    // The incoming vc_id picks the buffer; the switch allocator picks the reader.
    always_comb
    begin
        write_cmd = '0;
        read_cmd = '0;
        if (valid_flit_i)
            write_cmd[data_i.vc_id] = 1'b1;
        if (sa_read_i && !is_empty[sa_vc_sel_i])
            read_cmd[sa_vc_sel_i] = 1'b1;
    end

    assign flit_o = vc_data[sa_vc_sel_i];

endmodule

`default_nettype wire

// ==== vc_allocator.sv ====
`default_nettype none

module vc_allocator import noc_params::*; (
    input  wire logic                               clk,
    input  wire logic                               reset_i,
    input  wire va_req_t [PORT_NUM-1:0][VC_NUM-1:0] va_req_i,
    input  wire logic [PORT_NUM-1:0]                tail_sent_i,
    input  wire vc_id_t [PORT_NUM-1:0]              tail_vc_i,
    output va_grant_t [PORT_NUM-1:0][VC_NUM-1:0]    va_grant_o
);

    localparam int REQ_NUM = PORT_NUM * VC_NUM;  // every input VC may ask.

    typedef logic [$clog2(REQ_NUM)-1:0] req_idx_t;

    logic [PORT_NUM-1:0][VC_NUM-1:0] busy_q;     // downstream VC owned by a packet.
    logic [PORT_NUM-1:0][VC_NUM-1:0] grant_set;  // downstream VCs handed out this cycle.
    req_idx_t [PORT_NUM-1:0]         rr_q;
    req_idx_t [PORT_NUM-1:0]         winner;
    logic [PORT_NUM-1:0]             win_valid;

    // ##################################################
    // one grant per output per cycle
    // ##################################################
    always_comb
    begin
        int idx;
        int in_port;
        int in_vc;
        logic has_free;
        vc_id_t free_vc;
        va_grant_o = '0;
        grant_set = '0;
        winner = '0;
        win_valid = '0;
        for (int o = 0; o < PORT_NUM; o++)
        begin
            has_free = 1'b0;
            free_vc = '0;
            for (int v = VC_NUM - 1; v >= 0; v--)
            begin
                if (!busy_q[o][v])
                begin
                    has_free = 1'b1;
                    free_vc = vc_id_t'(v);  // the lowest free one survives the loop.
                end
            end
            // search starts at the requester after the last winner.
            for (int k = 0; k < REQ_NUM; k++)
            begin
                idx = int'(rr_q[o]) + k;
                if (idx >= REQ_NUM)
                    idx = idx - REQ_NUM;
                in_port = idx / VC_NUM;
                in_vc = idx % VC_NUM;
                if (has_free && !win_valid[o] && va_req_i[in_port][in_vc].valid
                        && va_req_i[in_port][in_vc].out_port == port_t'(o))
                begin
                    win_valid[o] = 1'b1;
                    winner[o] = req_idx_t'(idx);
                    va_grant_o[in_port][in_vc].valid = 1'b1;
                    va_grant_o[in_port][in_vc].vc_new = free_vc;
                    grant_set[o][free_vc] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            busy_q <= '0;
            rr_q <= '0;
        end
        else
        begin
            for (int o = 0; o < PORT_NUM; o++)
            begin
                busy_q[o] <= busy_q[o] | grant_set[o];
                if (tail_sent_i[o])
                    busy_q[o][tail_vc_i[o]] <= 1'b0;  // tail left, VC is free again.
                if (win_valid[o])
                    rr_q[o] <= (winner[o] == req_idx_t'(REQ_NUM - 1)) ? '0 : winner[o] + 1'b1;
            end
        end
    end

    // a downstream VC stays with one packet until the switch reports its tail.
    for (genvar o = 0; o < PORT_NUM; o++)
    begin : g_check
        for (genvar v = 0; v < VC_NUM; v++)
        begin : g_vc
            a_single_owner: assert property (@(posedge clk) disable iff (reset_i)
                grant_set[o][v] |=>
                    (!grant_set[o][v] until (tail_sent_i[o] && tail_vc_i[o] == vc_id_t'(v))))
                else $error("downstream VC granted twice before its tail left.");
        end
    end

endmodule

`default_nettype wire

// ==== switch_stage.sv ====
`default_nettype none

module switch_stage import noc_params::*; (
    input  wire logic                               clk,
    input  wire logic                               reset_i,
    input  wire sa_req_t [PORT_NUM-1:0][VC_NUM-1:0] sa_req_i,
    input  wire flit_t [PORT_NUM-1:0]               flit_i,
    input  wire logic [PORT_NUM-1:0][VC_NUM-1:0]    on_off_i,
    output vc_id_t [PORT_NUM-1:0]                   sa_vc_sel_o,
    output logic [PORT_NUM-1:0]                     sa_read_o,
    output flit_t [PORT_NUM-1:0]                    data_o,
    output logic [PORT_NUM-1:0]                     valid_flit_o,
    output logic [PORT_NUM-1:0]                     tail_sent_o,
    output vc_id_t [PORT_NUM-1:0]                   tail_vc_o
);

    typedef logic [$clog2(PORT_NUM)-1:0] port_idx_t;

    vc_id_t [PORT_NUM-1:0]             in_rr_q;
    port_idx_t [PORT_NUM-1:0]          out_rr_q;
    logic [PORT_NUM-1:0]               in_valid;  // input port has a VC that may move.
    sa_req_t [PORT_NUM-1:0]            in_req;
    logic [PORT_NUM-1:0][PORT_NUM-1:0] out_gnt;   // indexed [output][input].
    port_idx_t [PORT_NUM-1:0]          out_win;

    // ##################################################
    // first stage picks one VC per input port
    // ##################################################
    always_comb
    begin
        int v;
        in_valid = '0;
        in_req = '0;
        sa_vc_sel_o = in_rr_q;
        for (int p = 0; p < PORT_NUM; p++)
        begin
            for (int k = 0; k < VC_NUM; k++)
            begin
                v = (int'(in_rr_q[p]) + k) % VC_NUM;
                // a VC whose downstream buffer said off does not compete at all.
                if (!in_valid[p] && sa_req_i[p][v].valid
                        && on_off_i[sa_req_i[p][v].out_port][sa_req_i[p][v].vc_new])
                begin
                    in_valid[p] = 1'b1;
                    in_req[p] = sa_req_i[p][v];
                    sa_vc_sel_o[p] = vc_id_t'(v);
                end
            end
        end
    end

    // ##################################################
    // second stage picks one input port per output
    // ##################################################
    always_comb
    begin
        int p;
        out_gnt = '0;
        out_win = '0;
        for (int o = 0; o < PORT_NUM; o++)
        begin
            for (int k = 0; k < PORT_NUM; k++)
            begin
                p = (int'(out_rr_q[o]) + k) % PORT_NUM;
                if (out_gnt[o] == '0 && in_valid[p] && in_req[p].out_port == port_t'(o))
                begin
                    out_gnt[o][p] = 1'b1;
                    out_win[o] = port_idx_t'(p);
                end
            end
        end
    end

    always_comb
    begin
        sa_read_o = '0;
        for (int o = 0; o < PORT_NUM; o++)
        begin
            sa_read_o = sa_read_o | out_gnt[o];
            tail_sent_o[o] = (|out_gnt[o]) && in_req[out_win[o]].is_tail;
            tail_vc_o[o] = in_req[out_win[o]].vc_new;
        end
    end

    // Crossbar traversal into the output registers, relabelled for the next hop.
    always_ff @(posedge clk)
    begin
        for (int o = 0; o < PORT_NUM; o++)
        begin
            data_o[o] <= flit_i[out_win[o]];
            data_o[o].vc_id <= in_req[out_win[o]].vc_new;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            valid_flit_o <= '0;
            in_rr_q <= '0;
            out_rr_q <= '0;
        end
        else
        begin
            for (int o = 0; o < PORT_NUM; o++)
            begin
                valid_flit_o[o] <= |out_gnt[o];
                if (|out_gnt[o])
                    out_rr_q[o] <= port_idx_t'((int'(out_win[o]) + 1) % PORT_NUM);
            end
            for (int p = 0; p < PORT_NUM; p++)
            begin
                if (sa_read_o[p])
                    in_rr_q[p] <= vc_id_t'((int'(sa_vc_sel_o[p]) + 1) % VC_NUM);
            end
        end
    end

    for (genvar o = 0; o < PORT_NUM; o++)
    begin : g_check
        a_one_grant: assert property (@(posedge clk) disable iff (reset_i) $onehot0(out_gnt[o]))
            else $error("output granted to more than one input port.");
    end

endmodule

`default_nettype wire

// ==== router.sv ====
`default_nettype none

module router import noc_params::*; #(
    parameter int BUFFER_SIZE = 8,
    parameter int PIPELINE_DEPTH = 2,
    parameter int X_CURRENT = MESH_SIZE_X / 2,
    parameter int Y_CURRENT = MESH_SIZE_Y / 2
) (
    input  wire logic                            clk,
    input  wire logic                            reset_i,
    input  wire flit_t [PORT_NUM-1:0]            data_i,
    input  wire logic [PORT_NUM-1:0]             valid_flit_i,
    output logic [PORT_NUM-1:0][VC_NUM-1:0]      on_off_o,
    output flit_t [PORT_NUM-1:0]                 data_o,
    output logic [PORT_NUM-1:0]                  valid_flit_o,
    input  wire logic [PORT_NUM-1:0][VC_NUM-1:0] on_off_i
);

    va_req_t [PORT_NUM-1:0][VC_NUM-1:0]   va_req;
    va_grant_t [PORT_NUM-1:0][VC_NUM-1:0] va_grant;
    sa_req_t [PORT_NUM-1:0][VC_NUM-1:0]   sa_req;
    vc_id_t [PORT_NUM-1:0]                sa_vc_sel;
    logic [PORT_NUM-1:0]                  sa_read;
    flit_t [PORT_NUM-1:0]                 port_flit;  // front flit of the selected VC.
    logic [PORT_NUM-1:0]                  tail_sent;
    vc_id_t [PORT_NUM-1:0]                tail_vc;

    for (genvar p = 0; p < PORT_NUM; p++)
    begin : g_port
        input_port #(
            .BUFFER_SIZE(BUFFER_SIZE),
            .PIPELINE_DEPTH(PIPELINE_DEPTH),
            .X_CURRENT(X_CURRENT),
            .Y_CURRENT(Y_CURRENT)
        ) u_input_port (
            .clk(clk),
            .reset_i(reset_i),
            .data_i(data_i[p]),
            .valid_flit_i(valid_flit_i[p]),
            .va_grant_i(va_grant[p]),
            .sa_vc_sel_i(sa_vc_sel[p]),
            .sa_read_i(sa_read[p]),
            .flit_o(port_flit[p]),
            .va_req_o(va_req[p]),
            .sa_req_o(sa_req[p]),
            .on_off_o(on_off_o[p])
        );
    end

    vc_allocator u_vc_allocator (
        .clk(clk),
        .reset_i(reset_i),
        .va_req_i(va_req),
        .tail_sent_i(tail_sent),
        .tail_vc_i(tail_vc),
        .va_grant_o(va_grant)
    );

    switch_stage u_switch_stage (
        .clk(clk),
        .reset_i(reset_i),
        .sa_req_i(sa_req),
        .flit_i(port_flit),
        .on_off_i(on_off_i),
        .sa_vc_sel_o(sa_vc_sel),
        .sa_read_o(sa_read),
        .data_o(data_o),
        .valid_flit_o(valid_flit_o),
        .tail_sent_o(tail_sent),
        .tail_vc_o(tail_vc)
    );

endmodule

`default_nettype wire

// ==== tb_router.sv ====
`default_nettype none

module tb_router import noc_params::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int X_POS = 1;
    localparam int Y_POS = 1;
    localparam int BUF_DEPTH = 8;
    localparam int PIPE_DEPTH = 2;
    localparam int SEED = 19565;
    localparam int MAX_FLITS = 8;
    // the five tests need roughly 500 cycles in all.
    localparam int TIMEOUT_CYCLES = 2000;

    logic                            clk;
    logic                            reset;
    flit_t [PORT_NUM-1:0]            data_in;
    logic [PORT_NUM-1:0]             valid_in;
    logic [PORT_NUM-1:0][VC_NUM-1:0] on_off_up;
    flit_t [PORT_NUM-1:0]            data_out;
    logic [PORT_NUM-1:0]             valid_out;
    logic [PORT_NUM-1:0][VC_NUM-1:0] on_off_down;

    flit_t rx_q [PORT_NUM][$];        // flits seen on each output, oldest first.
    flit_t pkt [2][MAX_FLITS];        // packets of the running test.
    int    pkt_len [2];
    int    cycle_count;

    router #(
        .BUFFER_SIZE(BUF_DEPTH),
        .PIPELINE_DEPTH(PIPE_DEPTH),
        .X_CURRENT(X_POS),
        .Y_CURRENT(Y_POS)
    ) u_dut (
        .clk(clk),
        .reset_i(reset),
        .data_i(data_in),
        .valid_flit_i(valid_in),
        .on_off_o(on_off_up),
        .data_o(data_out),
        .valid_flit_o(valid_out),
        .on_off_i(on_off_down)
    );

    always #10 clk = ~clk;

    // outputs are registered, so the falling edge sees them settled.
    always @(negedge clk)
    begin
        if (!reset)
        begin
            for (int p = 0; p < PORT_NUM; p++)
            begin
                if (valid_out[p])
                    rx_q[p].push_back(data_out[p]);
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
            abort_run("timeout, the router stopped delivering flits.");
    end

    // ##################################################
    // reporting and checks
    // ##################################################
    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_flit(string name, flit_t expected, flit_t actual);
        if (expected !== actual)
            abort_run($sformatf("Mismatch in %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (expected !== actual)
            abort_run($sformatf("Mismatch in %s: expected %b, actual %b", name, expected, actual));
    endtask

    function automatic void make_packet(int idx, int vc, int x, int y, int len);
        head_payload_t hp;
        hp.x_dest = x_addr_t'(x);
        hp.y_dest = y_addr_t'(y);
        hp.head_data = HEAD_DATA_SIZE'($urandom());
        pkt_len[idx] = len;
        for (int i = 0; i < len; i++)
        begin
            pkt[idx][i].vc_id = vc_id_t'(vc);
            pkt[idx][i].payload = (i == 0) ? payload_t'(hp) : payload_t'($urandom());
            if (len == 1)
                pkt[idx][i].label = HEADTAIL;
            else if (i == 0)
                pkt[idx][i].label = HEAD;
            else if (i == len - 1)
                pkt[idx][i].label = TAIL;
            else
                pkt[idx][i].label = BODY;
        end
    endfunction

    // ##################################################
    // drive and collect
    // ##################################################
    task automatic send_flit(port_t port, flit_t flit);
        @(posedge clk);
        #2;
        data_in[port] = flit;
        valid_in[port] = 1'b1;
    endtask

    task automatic end_send(port_t port);
        @(posedge clk);
        #2;
        valid_in[port] = 1'b0;
    endtask

    task automatic send_packet(port_t port, int idx);
        for (int i = 0; i < pkt_len[idx]; i++)
            send_flit(port, pkt[idx][i]);
        end_send(port);
    endtask

    task automatic set_on_off(port_t port, logic on);
        @(posedge clk);
        #2;
        on_off_down[port] = {VC_NUM{on}};
    endtask

    task automatic wait_flits(port_t port, int n);
        while (rx_q[port].size() < n)
            @(negedge clk);
    endtask

    function automatic int total_rx();
        int sum;
        sum = 0;
        for (int p = 0; p < PORT_NUM; p++)
            sum += rx_q[p].size();
        return sum;
    endfunction

    function automatic void clear_rx();
        for (int p = 0; p < PORT_NUM; p++)
            rx_q[p].delete();
    endfunction

    // a packet on a freshly free output takes the lowest downstream VC.
    task automatic check_packet(string name, port_t port, int idx, int vc_out);
        flit_t expected;
        flit_t got;
        for (int i = 0; i < pkt_len[idx]; i++)
        begin
            expected = pkt[idx][i];
            expected.vc_id = vc_id_t'(vc_out);
            got = rx_q[port].pop_front();
            check_flit(name, expected, got);
        end
    endtask

    // ##################################################
    // tests
    // ##################################################
    task automatic test_routing();
        int    dest_x [5] = '{2, 0, 1, 1, 1};
        int    dest_y [5] = '{1, 1, 2, 0, 1};
        // seen from (1,1), X is settled first and y grows towards the south.
        port_t exp_port [5] = '{EAST, WEST, SOUTH, NORTH, LOCAL};
        for (int d = 0; d < 5; d++)
        begin
            clear_rx();
            make_packet(0, 0, dest_x[d], dest_y[d], 1);
            send_packet(LOCAL, 0);
            wait_flits(exp_port[d], 1);
            repeat (3) @(negedge clk);
            check_bit("routing", 1'b1, total_rx() == 1);  // nothing leaks to other ports.
            check_packet("routing", exp_port[d], 0, 0);
        end
    endtask

    task automatic test_ordering();
        clear_rx();
        make_packet(0, 1, 2, 1, 4);  // input VC 1 is relabelled on the way out.
        send_packet(LOCAL, 0);
        wait_flits(EAST, 4);
        repeat (3) @(negedge clk);
        check_bit("ordering", 1'b1, total_rx() == 4);
        check_packet("ordering", EAST, 0, 0);
    endtask

    task automatic test_contention();
        int    pos [VC_NUM];
        int    cur [VC_NUM];
        logic  [1:0] seen;
        flit_t expected;
        flit_t got;
        clear_rx();
        make_packet(0, 0, 2, 1, 4);
        make_packet(1, 0, 2, 1, 4);
        if (pkt[1][0].payload == pkt[0][0].payload)
            pkt[1][0].payload[0] = ~pkt[1][0].payload[0];  // heads must tell the packets apart.
        fork
            send_packet(WEST, 0);
            send_packet(NORTH, 1);
        join
        wait_flits(EAST, 8);
        repeat (3) @(negedge clk);
        check_bit("contention", 1'b1, total_rx() == 8);
        seen = '0;
        for (int v = 0; v < VC_NUM; v++)
        begin
            pos[v] = 0;
            cur[v] = 0;
        end
        // each output VC must carry whole packets, one after the other.
        while (rx_q[EAST].size() > 0)
        begin
            got = rx_q[EAST].pop_front();
            if (pos[got.vc_id] == 0)
                cur[got.vc_id] = (got.payload == pkt[1][0].payload) ? 1 : 0;
            expected = pkt[cur[got.vc_id]][pos[got.vc_id]];
            expected.vc_id = got.vc_id;
            check_flit("contention", expected, got);
            seen[cur[got.vc_id]] = 1'b1;
            pos[got.vc_id] = (pos[got.vc_id] == 3) ? 0 : pos[got.vc_id] + 1;
        end
        check_bit("contention", 1'b1, &seen);
    endtask

    task automatic test_back_pressure();
        clear_rx();
        set_on_off(EAST, 1'b0);
        make_packet(0, 0, 2, 1, 4);
        send_packet(LOCAL, 0);
        repeat (30)
        begin
            @(negedge clk);
            check_bit("back_pressure", 1'b0, valid_out[EAST]);
        end
        set_on_off(EAST, 1'b1);
        wait_flits(EAST, 4);
        repeat (3) @(negedge clk);
        check_bit("back_pressure", 1'b1, total_rx() == 4);
        check_packet("back_pressure", EAST, 0, 0);
    endtask

    task automatic test_flow_control();
        int len;
        len = BUF_DEPTH - 1;  // the last flit goes in while on_off is still high.
        clear_rx();
        set_on_off(EAST, 1'b0);
        make_packet(0, 0, 2, 1, len);
        for (int k = 1; k <= len; k++)
        begin
            send_flit(LOCAL, pkt[0][k-1]);
            end_send(LOCAL);
            @(negedge clk);
            check_bit("flow_control", k <= BUF_DEPTH - PIPE_DEPTH, on_off_up[LOCAL][0]);
        end
        set_on_off(EAST, 1'b1);
        wait_flits(EAST, len);
        repeat (3) @(negedge clk);
        check_bit("flow_control", 1'b1, on_off_up[LOCAL][0]);
        check_packet("flow_control", EAST, 0, 0);
    endtask

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        data_in = '0;
        valid_in = '0;
        on_off_down = '1;
        cycle_count = 0;
        void'($urandom(SEED));
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        check_bit("reset", 1'b1, &on_off_up);
        check_bit("reset", 1'b0, |valid_out);

        test_routing();
        test_ordering();
        test_contention();
        test_back_pressure();
        test_flow_control();

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
noc_params.sv
rc_unit.sv
input_buffer.sv
input_port.sv
vc_allocator.sv
switch_stage.sv
router.sv
tb_router.sv
